// ==== verilog/core_mem_pkg.sv ====
/* Core memory package
   Widths, DMEM op codes and the structs shared by the data-memory path */
`default_nettype none

package core_mem_pkg;

  ////////////////////
  // Memory geometry
  ////////////////////
  localparam int DATA_WIDTH = 64;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int WORD_LSB   = $clog2(STRB_WIDTH);

  localparam int DMEM_SIZE_BYTES      = 32768;
  localparam int DMEM_ADDR_WIDTH      = $clog2(DMEM_SIZE_BYTES);
  localparam int DMEM_WORD_ADDR_WIDTH = DMEM_ADDR_WIDTH - WORD_LSB;

  // Broadcast messages carry half a memory word
  localparam int MSG_DATA_WIDTH = 32;
  localparam int MSG_STRB_WIDTH = MSG_DATA_WIDTH / 8;

  // Write and read are bitwise inverses so a turnaround is a plain invert
  typedef enum logic [1:0] {
    DMEM_IDLE  = 2'b00,
    DMEM_WRITE = 2'b01,
    DMEM_READ  = 2'b10
  } dmem_op_t;

  ////////////////////
  // Port structs
  ////////////////////
  typedef struct packed {
    logic [DMEM_ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]      data;
    logic [STRB_WIDTH-1:0]      strb;
    logic                       last;
  } mem_wr_cmd_t;

  typedef struct packed {
    logic [DMEM_ADDR_WIDTH-1:0] addr;
    logic                       last;
  } mem_rd_cmd_t;

  typedef struct packed {
    logic [MSG_STRB_WIDTH-1:0]  strb;
    logic [DMEM_ADDR_WIDTH-1:0] addr;
    logic [MSG_DATA_WIDTH-1:0]  data;
  } core_msg_t;

  // One memory access as seen by the RAM
  typedef struct packed {
    logic                            en;
    logic                            ren;
    logic [STRB_WIDTH-1:0]           wen;
    logic [DMEM_WORD_ADDR_WIDTH-1:0] word_addr;
    logic [DATA_WIDTH-1:0]           wdata;
  } dmem_req_t;

endpackage

`default_nettype wire

// ==== verilog/core_msg_align.sv ====
/* Core message aligner
   Registers a broadcast message and places it on its half of the memory word */
`timescale 1ns/1ps
`default_nettype none

module core_msg_align
  import core_mem_pkg::*;
(
  input  wire                             clk,
  input  wire                             rst,
  input  wire core_msg_t                  core_msg_in,
  input  wire                             core_msg_valid,
  output logic                            msg_req_valid,
  output logic [STRB_WIDTH-1:0]           msg_wen,
  output logic [DMEM_WORD_ADDR_WIDTH-1:0] msg_word_addr,
  output logic [DATA_WIDTH-1:0]           msg_wdata
);

  localparam int LANE_BIT = $clog2(MSG_STRB_WIDTH);
  localparam int PAD_STRB = STRB_WIDTH - MSG_STRB_WIDTH;
  localparam int PAD_DATA = DATA_WIDTH - MSG_DATA_WIDTH;

  core_msg_t msg_r;
  logic      upper_lane;

  // Register the message and its valid
  always_ff @(posedge clk) begin
    msg_r <= core_msg_in;
    if (rst) begin
      msg_req_valid <= 1'b0;
    end else begin
      msg_req_valid <= core_msg_valid;
    end
  end

  // Address bit 2 picks the upper or lower 32-bit lane
  assign upper_lane    = msg_r.addr[LANE_BIT];
  assign msg_word_addr = msg_r.addr[DMEM_ADDR_WIDTH-1:WORD_LSB];

  always_comb begin
    if (upper_lane) begin
      msg_wen   = {msg_r.strb, {PAD_STRB{1'b0}}};
      msg_wdata = {msg_r.data, {PAD_DATA{1'b0}}};
    end else begin
      msg_wen   = {{PAD_STRB{1'b0}}, msg_r.strb};
      msg_wdata = {{PAD_DATA{1'b0}}, msg_r.data};
    end
  end

  // A registered message writes at least one byte lane
  a_msg_has_strobe: assert property (
    @(posedge clk) disable iff (rst)
    msg_req_valid |-> (msg_wen != '0)
  ) else $error("core message registered with empty strobe");

endmodule

`default_nettype wire

// ==== verilog/dmem_arbiter.sv ====
/* DMEM arbiter
   Grants one DMA read or write per cycle, core messages first */
`timescale 1ns/1ps
`default_nettype none

module dmem_arbiter
  import core_mem_pkg::*;
#(
  parameter int INTERLEAVE = 1
) (
  input  wire                            clk,
  input  wire                            rst,
  input  wire mem_wr_cmd_t               wr_cmd,
  input  wire                            wr_en,
  output logic                           wr_ready,
  input  wire mem_rd_cmd_t               rd_cmd,
  input  wire                            rd_en,
  output logic                           rd_ready,
  input  wire                            rd_resp_ready,
  output logic                           rd_resp_valid,
  input  wire                            msg_req_valid,
  input  wire [STRB_WIDTH-1:0]           msg_wen,
  input  wire [DMEM_WORD_ADDR_WIDTH-1:0] msg_word_addr,
  input  wire [DATA_WIDTH-1:0]           msg_wdata,
  output dmem_req_t                      dmem_req
);

  dmem_op_t dmem_op;
  dmem_op_t prev_op;
  logic     burst_switch;
  logic     read_reject;
  logic     read_rejected;
  logic     read_accepted_r;
  logic     dma_rd_req;

  // A response held by the consumer blocks any new read
  assign read_reject = rd_resp_valid && !rd_resp_ready;
  assign dma_rd_req  = rd_en && !read_reject;

  ////////////////////
  // Op selection
  ////////////////////
  always_comb begin
    if (msg_req_valid) begin
      // message owns the port this cycle
      dmem_op = DMEM_IDLE;
    end else begin
      case ({wr_en, dma_rd_req})
        2'b01: dmem_op = DMEM_READ;
        2'b10: dmem_op = DMEM_WRITE;
        2'b11: begin
          // Coming out of idle always starts with the write
          if (prev_op == DMEM_IDLE) begin
            dmem_op = DMEM_WRITE;
          end else if ((INTERLEAVE != 0) || burst_switch) begin
            dmem_op = dmem_op_t'(~prev_op);
          end else begin
            dmem_op = prev_op;
          end
        end
        default: dmem_op = DMEM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      prev_op         <= DMEM_IDLE;
      burst_switch    <= 1'b0;
      read_accepted_r <= 1'b0;
      read_rejected   <= 1'b0;
    end else begin
      prev_op         <= dmem_op;
      // Last beat of a burst lets the other side in next cycle
      burst_switch    <= ((dmem_op == DMEM_READ) && rd_cmd.last) ||
                         ((dmem_op == DMEM_WRITE) && wr_cmd.last);
      read_accepted_r <= (dmem_op == DMEM_READ);
      read_rejected   <= read_reject;
    end
  end

  ////////////////////
  // Handshakes
  ////////////////////
  assign rd_ready      = (dmem_op == DMEM_READ);
  assign wr_ready      = !(wr_en && (dmem_op != DMEM_WRITE));

  // Valid follows an accepted read and stays up while it is refused
  assign rd_resp_valid = read_accepted_r || read_rejected;

  ////////////////////
  // Memory request
  ////////////////////
  always_comb begin
    dmem_req.en  = msg_req_valid || (dmem_op != DMEM_IDLE);
    dmem_req.ren = (dmem_op == DMEM_READ);
    if (msg_req_valid) begin
      dmem_req.wen       = msg_wen;
      dmem_req.word_addr = msg_word_addr;
      dmem_req.wdata     = msg_wdata;
    end else if (dmem_op == DMEM_WRITE) begin
      dmem_req.wen       = wr_cmd.strb;
      dmem_req.word_addr = wr_cmd.addr[DMEM_ADDR_WIDTH-1:WORD_LSB];
      dmem_req.wdata     = wr_cmd.data;
    end else begin
      dmem_req.wen       = '0;
      dmem_req.word_addr = rd_cmd.addr[DMEM_ADDR_WIDTH-1:WORD_LSB];
      dmem_req.wdata     = wr_cmd.data;
    end
  end

  // Message, DMA write and DMA read never share the port
  a_one_owner: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0({msg_req_valid, rd_ready, wr_en && wr_ready})
  ) else $error("more than one DMEM access granted");

  // No read reaches the RAM while a response is refused
  a_stall_holds: assert property (
    @(posedge clk) disable iff (rst)
    read_reject |-> !dmem_req.ren
  ) else $error("read issued while response was waiting");

endmodule

`default_nettype wire

// ==== verilog/dmem_ram.sv ====
/* Local data memory
   Single port, byte-strobe writes, registered read data */
`timescale 1ns/1ps
`default_nettype none

module dmem_ram
  import core_mem_pkg::*;
#(
  parameter int DMEM_SIZE_BYTES = core_mem_pkg::DMEM_SIZE_BYTES
) (
  input  wire                   clk,
  input  wire dmem_req_t        dmem_req,
  output logic [DATA_WIDTH-1:0] rd_data
);

  localparam int DEPTH     = DMEM_SIZE_BYTES / STRB_WIDTH;
  localparam int IDX_WIDTH = $clog2(DEPTH);

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [IDX_WIDTH-1:0]  idx;

  // Upper word address bits fall away when the memory is built smaller
  assign idx = dmem_req.word_addr[IDX_WIDTH-1:0];

  ////////////////////
  // Write port
  ////////////////////
  always_ff @(posedge clk) begin
    if (dmem_req.en) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (dmem_req.wen[i]) begin
          mem[idx][i*8 +: 8] <= dmem_req.wdata[i*8 +: 8];
        end
      end
    end
  end

  ////////////////////
  // Read port
  ////////////////////
  // Output register moves only on a read, so a stalled response keeps its word
  always_ff @(posedge clk) begin
    if (dmem_req.en && dmem_req.ren) begin
      rd_data <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/core_mem_port.sv ====
/* Core memory port
   DMA commands and core messages sharing the local DMEM */
`timescale 1ns/1ps
`default_nettype none

module core_mem_port
  import core_mem_pkg::*;
#(
  parameter int INTERLEAVE      = 1,
  parameter int DMEM_SIZE_BYTES = core_mem_pkg::DMEM_SIZE_BYTES
) (
  input  wire                   clk,
  input  wire                   rst,

  // DMA write commands
  input  wire mem_wr_cmd_t      wr_cmd,
  input  wire                   wr_en,
  output logic                  wr_ready,

  // DMA read commands
  input  wire mem_rd_cmd_t      rd_cmd,
  input  wire                   rd_en,
  output logic                  rd_ready,

  // Read responses
  output logic [DATA_WIDTH-1:0] rd_resp_data,
  output logic                  rd_resp_valid,
  input  wire                   rd_resp_ready,

  // Broadcast messages from other cores, no back-pressure
  input  wire core_msg_t        core_msg_in,
  input  wire                   core_msg_valid
);

  logic                            msg_req_valid;
  logic [STRB_WIDTH-1:0]           msg_wen;
  logic [DMEM_WORD_ADDR_WIDTH-1:0] msg_word_addr;
  logic [DATA_WIDTH-1:0]           msg_wdata;
  dmem_req_t                       dmem_req;

  ////////////////////
  // Message path
  ////////////////////
  core_msg_align u_msg_align (
    .clk           (clk),
    .rst           (rst),
    .core_msg_in   (core_msg_in),
    .core_msg_valid(core_msg_valid),
    .msg_req_valid (msg_req_valid),
    .msg_wen       (msg_wen),
    .msg_word_addr (msg_word_addr),
    .msg_wdata     (msg_wdata)
  );

  ////////////////////
  // Arbitration
  ////////////////////
  dmem_arbiter #(
    .INTERLEAVE(INTERLEAVE)
  ) u_arbiter (
    .clk          (clk),
    .rst          (rst),
    .wr_cmd       (wr_cmd),
    .wr_en        (wr_en),
    .wr_ready     (wr_ready),
    .rd_cmd       (rd_cmd),
    .rd_en        (rd_en),
    .rd_ready     (rd_ready),
    .rd_resp_ready(rd_resp_ready),
    .rd_resp_valid(rd_resp_valid),
    .msg_req_valid(msg_req_valid),
    .msg_wen      (msg_wen),
    .msg_word_addr(msg_word_addr),
    .msg_wdata    (msg_wdata),
    .dmem_req     (dmem_req)
  );

  ////////////////////
  // Data memory
  ////////////////////
  // Read data goes straight out, the RAM register holds it under stall
  dmem_ram #(
    .DMEM_SIZE_BYTES(DMEM_SIZE_BYTES)
  ) u_dmem (
    .clk     (clk),
    .dmem_req(dmem_req),
    .rd_data (rd_resp_data)
  );

endmodule

`default_nettype wire

// ==== test/core_mem_checker.sv ====
/* Core memory checker
   Shadow DMEM that predicts read responses and checks the port rules */
`timescale 1ns/1ps
`default_nettype none

module core_mem_checker
  import core_mem_pkg::*;
(
  input  wire                  clk,
  input  wire                  rst,
  input  wire mem_wr_cmd_t     wr_cmd,
  input  wire                  wr_en,
  input  wire                  wr_ready,
  input  wire mem_rd_cmd_t     rd_cmd,
  input  wire                  rd_en,
  input  wire                  rd_ready,
  input  wire [DATA_WIDTH-1:0] rd_resp_data,
  input  wire                  rd_resp_valid,
  input  wire                  rd_resp_ready,
  input  wire core_msg_t       core_msg_in,
  input  wire                  core_msg_valid,
  output int                   error_count,
  output int                   check_count,
  output int                   read_count,
  output int                   outstanding
);

  logic [DATA_WIDTH-1:0]           shadow [DMEM_SIZE_BYTES / STRB_WIDTH];
  logic [DATA_WIDTH-1:0]           exp_data_q [$];
  logic [DMEM_WORD_ADDR_WIDTH-1:0] exp_addr_q [$];
  core_msg_t                       msg_pend;
  logic                            msg_pend_valid;
  logic                            stalled;
  logic                            read_prev;
  logic [DATA_WIDTH-1:0]           stalled_data;

  task automatic report_error(input string what);
    error_count++;
    $display("error at %0t: %s", $time, what);
  endtask

  always @(posedge clk) begin
    logic [DMEM_WORD_ADDR_WIDTH-1:0] waddr;
    logic [DMEM_WORD_ADDR_WIDTH-1:0] raddr;
    logic [DATA_WIDTH-1:0]           expected;
    int                              lane;
    if (rst) begin
      error_count = 0;
      check_count = 0;
      read_count  = 0;
      exp_data_q.delete();
      exp_addr_q.delete();
    end else begin
      if (rd_resp_valid && (read_count == 0)) begin
        report_error("response valid before any read was accepted");
      end
      if (read_prev && !rd_resp_valid) begin
        report_error("no response in the cycle after a read");
      end
      if (stalled && !rd_resp_valid) begin
        report_error("stalled response dropped its valid");
      end
      if (stalled && rd_resp_valid && (rd_resp_data !== stalled_data)) begin
        error_count++;
        $display("mismatch at %0t: stalled data moved from 0x%h to 0x%h",
                 $time, stalled_data, rd_resp_data);
      end
      if (rd_resp_valid && !rd_resp_ready && rd_ready) begin
        report_error("read accepted while a response was waiting");
      end
      if (msg_pend_valid && (rd_ready || (wr_en && wr_ready))) begin
        report_error("DMA command accepted in a message write cycle");
      end

      // Responses leave in order, the oldest read is compared
      if (rd_resp_valid && rd_resp_ready) begin
        if (exp_data_q.size() == 0) begin
          report_error("response taken with no read outstanding");
        end else begin
          expected = exp_data_q.pop_front();
          raddr    = exp_addr_q.pop_front();
          check_count++;
          if (rd_resp_data !== expected) begin
            error_count++;
            $display("mismatch at %0t: word 0x%h (byte 0x%h) expected 0x%h got 0x%h",
                     $time, raddr, {raddr, 3'b000}, expected, rd_resp_data);
          end
        end
      end

      // Read sees the word before any write of this cycle
      if (rd_en && rd_ready) begin
        raddr = rd_cmd.addr[DMEM_ADDR_WIDTH-1:WORD_LSB];
        exp_data_q.push_back(shadow[raddr]);
        exp_addr_q.push_back(raddr);
        read_count++;
      end

      // Message seen last cycle lands now, address bit 2 picks the half
      if (msg_pend_valid) begin
        waddr = msg_pend.addr[DMEM_ADDR_WIDTH-1:WORD_LSB];
        for (int i = 0; i < MSG_STRB_WIDTH; i++) begin
          lane = msg_pend.addr[2] ? i + MSG_STRB_WIDTH : i;
          if (msg_pend.strb[i]) begin
            shadow[waddr][lane*8 +: 8] = msg_pend.data[i*8 +: 8];
          end
        end
      end
      if (wr_en && wr_ready) begin
        waddr = wr_cmd.addr[DMEM_ADDR_WIDTH-1:WORD_LSB];
        for (int i = 0; i < STRB_WIDTH; i++) begin
          if (wr_cmd.strb[i]) begin
            shadow[waddr][i*8 +: 8] = wr_cmd.data[i*8 +: 8];
          end
        end
      end
    end
    msg_pend       = core_msg_in;
    msg_pend_valid = core_msg_valid && !rst;
    stalled        = rd_resp_valid && !rd_resp_ready && !rst;
    stalled_data   = rd_resp_data;
    read_prev      = rd_en && rd_ready && !rst;
    outstanding    = exp_data_q.size();
  end

endmodule

`default_nettype wire

// ==== test/core_mem_port_tb.sv ====
/* Core memory port testbench
   Table-driven DMA and message traffic with checked read responses */
`timescale 1ns/1ps
`default_nettype none

module core_mem_port_tb
  import core_mem_pkg::*;
();

  localparam int  NUM_ROWS       = 13;
  localparam int  CYCLES_PER_ROW = 200;
  localparam int  RESET_CYCLES   = 16;
  localparam real CLK_PERIOD     = 8.0;

  typedef enum logic [2:0] {
    K_WRITE,
    K_READ,
    K_MIXED,
    K_MSG,
    K_IDLE
  } kind_t;

  typedef struct packed {
    kind_t                      kind;
    logic [DMEM_ADDR_WIDTH-1:0] addr;
    logic [7:0]                 beats;
    logic [DATA_WIDTH-1:0]      data;
    logic [STRB_WIDTH-1:0]      strb;
    logic                       bp;
  } stim_row_t;

  logic                  clk;
  logic                  rst;
  mem_wr_cmd_t           wr_cmd;
  logic                  wr_en;
  logic                  wr_ready;
  mem_rd_cmd_t           rd_cmd;
  logic                  rd_en;
  logic                  rd_ready;
  logic [DATA_WIDTH-1:0] rd_resp_data;
  logic                  rd_resp_valid;
  logic                  rd_resp_ready;
  core_msg_t             core_msg_in;
  logic                  core_msg_valid;
  int                    error_count;
  int                    check_count;
  int                    read_count;
  int                    outstanding;
  stim_row_t             rows [NUM_ROWS];
  logic [31:0]           lcg_state;

  core_mem_port #(.INTERLEAVE(1)) dut (
    .clk(clk), .rst(rst),
    .wr_cmd(wr_cmd), .wr_en(wr_en), .wr_ready(wr_ready),
    .rd_cmd(rd_cmd), .rd_en(rd_en), .rd_ready(rd_ready),
    .rd_resp_data(rd_resp_data), .rd_resp_valid(rd_resp_valid),
    .rd_resp_ready(rd_resp_ready),
    .core_msg_in(core_msg_in), .core_msg_valid(core_msg_valid)
  );

  core_mem_checker u_check (
    .clk(clk), .rst(rst),
    .wr_cmd(wr_cmd), .wr_en(wr_en), .wr_ready(wr_ready),
    .rd_cmd(rd_cmd), .rd_en(rd_en), .rd_ready(rd_ready),
    .rd_resp_data(rd_resp_data), .rd_resp_valid(rd_resp_valid),
    .rd_resp_ready(rd_resp_ready),
    .core_msg_in(core_msg_in), .core_msg_valid(core_msg_valid),
    .error_count(error_count), .check_count(check_count),
    .read_count(read_count), .outstanding(outstanding)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2.0) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Each beat gets its own word so reordered data cannot pass
  function automatic logic [DATA_WIDTH-1:0] beat_data(input logic [DATA_WIDTH-1:0] base,
                                                      input int beat);
    return base + 64'(beat) * 64'h0001_0203_0405_0607;
  endfunction

  function automatic string kind_name(input kind_t kind);
    case (kind)
      K_WRITE: return "write";
      K_READ:  return "read";
      K_MIXED: return "mixed";
      K_MSG:   return "message";
      default: return "idle";
    endcase
  endfunction

  task automatic init_inputs();
    rst            = 1'b1;
    wr_cmd         = '0;
    wr_en          = 1'b0;
    rd_cmd         = '0;
    rd_en          = 1'b0;
    rd_resp_ready  = 1'b1;
    core_msg_in    = '0;
    core_msg_valid = 1'b0;
  endtask

  ////////////////////
  // Stimulus table
  ////////////////////
  // First two rows fill every word that later rows read
  task automatic load_table();
    rows[0]  = '{K_WRITE, 15'h0200, 8'd16, 64'h1122_3344_5566_7788, 8'hFF, 1'b0};
    rows[1]  = '{K_WRITE, 15'h0280, 8'd16, 64'hA5A5_0F0F_C3C3_9696, 8'hFF, 1'b0};
    rows[2]  = '{K_READ,  15'h0200, 8'd4,  64'h0,                   8'h00, 1'b0};
    rows[3]  = '{K_WRITE, 15'h0200, 8'd8,  64'hDEAD_BEEF_0BAD_F00D, 8'h5A, 1'b0};
    rows[4]  = '{K_READ,  15'h0200, 8'd8,  64'h0,                   8'h00, 1'b0};
    rows[5]  = '{K_MIXED, 15'h0240, 8'd6,  64'h0123_4567_89AB_CDEF, 8'hF0, 1'b0};
    rows[6]  = '{K_MSG,   15'h0208, 8'd4,  64'h0000_0000_CAFE_D00D, 8'h0B, 1'b0};
    rows[7]  = '{K_MSG,   15'h020C, 8'd0,  64'h0000_0000_7E57_1234, 8'h06, 1'b0};
    rows[8]  = '{K_READ,  15'h0200, 8'd4,  64'h0,                   8'h00, 1'b0};
    rows[9]  = '{K_IDLE,  15'h0000, 8'd5,  64'h0,                   8'h00, 1'b0};
    rows[10] = '{K_READ,  15'h0200, 8'd16, 64'h0,                   8'h00, 1'b1};
    rows[11] = '{K_MIXED, 15'h0280, 8'd8,  64'h5555_AAAA_3333_CCCC, 8'h3C, 1'b1};
    rows[12] = '{K_READ,  15'h0240, 8'd12, 64'h0,                   8'h00, 1'b1};
  endtask

  // Message rows run their DMA beats 64 bytes above the message word
  task automatic run_row(input stim_row_t row);
    int                         wr_left;
    int                         rd_left;
    int                         resp_left;
    int                         idle_left;
    int                         wi;
    int                         ri;
    logic                       send_msg;
    logic [DMEM_ADDR_WIDTH-1:0] base;
    base      = (row.kind == K_MSG) ? row.addr + 15'd64 : row.addr;
    wr_left   = (row.kind inside {K_WRITE, K_MIXED, K_MSG}) ? int'(row.beats) : 0;
    rd_left   = (row.kind inside {K_READ, K_MIXED, K_MSG}) ? int'(row.beats) : 0;
    idle_left = (row.kind == K_IDLE) ? int'(row.beats) : 0;
    send_msg  = (row.kind == K_MSG);
    resp_left = 0;
    wi        = 0;
    ri        = 0;
    while ((wr_left > 0) || (rd_left > 0) || (resp_left > 0) || (idle_left > 0) || send_msg) begin
      @(negedge clk);
      wr_en            = (wr_left > 0);
      wr_cmd.addr      = base + DMEM_ADDR_WIDTH'(wi * STRB_WIDTH);
      wr_cmd.data      = beat_data(row.data, wi);
      wr_cmd.strb      = row.strb;
      wr_cmd.last      = (wr_left == 1);
      rd_en            = (rd_left > 0);
      rd_cmd.addr      = base + DMEM_ADDR_WIDTH'(ri * STRB_WIDTH);
      rd_cmd.last      = (rd_left == 1);
      core_msg_valid   = send_msg;
      core_msg_in.strb = row.strb[MSG_STRB_WIDTH-1:0];
      core_msg_in.addr = row.addr;
      core_msg_in.data = row.data[MSG_DATA_WIDTH-1:0];
      send_msg         = 1'b0;
      if (row.bp) begin
        lcg_state     = lcg_next(lcg_state);
        rd_resp_ready = lcg_state[16];
      end else begin
        rd_resp_ready = 1'b1;
      end
      // Sample handshakes just before the rising edge
      #(CLK_PERIOD / 2.0 - 1.0);
      if (wr_en && wr_ready) begin
        wr_left--;
        wi++;
      end
      if (rd_en && rd_ready) begin
        rd_left--;
        ri++;
        resp_left++;
      end
      if (rd_resp_valid && rd_resp_ready) begin
        resp_left--;
      end
      if (idle_left > 0) begin
        idle_left--;
      end
    end
    @(negedge clk);
    wr_en          = 1'b0;
    rd_en          = 1'b0;
    core_msg_valid = 1'b0;
    rd_resp_ready  = 1'b1;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    lcg_state = 32'd31403;
    init_inputs();
    load_table();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(rows[r]);
      $display("row %0d %s addr 0x%h beats %0d done, errors %0d",
               r, kind_name(rows[r].kind), rows[r].addr, rows[r].beats, error_count);
    end
    repeat (4) @(negedge clk);
    if (outstanding != 0) begin
      $display("error: %0d read responses never came back", outstanding);
    end
    $display("reads %0d, responses checked %0d, errors %0d",
             read_count, check_count, error_count);
    if ((error_count == 0) && (outstanding == 0)) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    repeat (RESET_CYCLES + NUM_ROWS * CYCLES_PER_ROW) @(posedge clk);
    $display("error: watchdog expired, traffic did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/core_mem_pkg.sv
verilog/core_msg_align.sv
verilog/dmem_arbiter.sv
verilog/dmem_ram.sv
verilog/core_mem_port.sv
test/core_mem_checker.sv
test/core_mem_port_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the core memory port testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module core_mem_port_tb -Mdir obj_dir -o core_mem_port_sim > build.log 2>&1 \
  && ./obj_dir/core_mem_port_sim > sim.log 2>&1 \
  || echo "build or simulation did not complete, see build.log and sim.log"

grep -qx "SIMULATION PASSED" sim.log && echo "PASS" && exit 0 \
  || { echo "FAIL"; exit 1; }
